//--- logic/gps_pkg.sv
`default_nettype none

package gps_pkg;

   localparam int N_CHANNELS     = 4;    // Correlator channels
   localparam int CODE_LEN       = 1023; // Chips per C/A epoch
   localparam int ACC_WIDTH      = 14;   // Signed I/Q accumulator
   localparam int I2Q2_WIDTH     = 28;   // Energy value
   localparam int CHAN_ID_WIDTH  = 2;
   localparam int SAMPLE_WIDTH   = 3;    // Baseband I or Q
   localparam int PRN_WIDTH      = 5;    // Stores PRN minus one
   localparam int CHIP_IDX_WIDTH = 10;
   localparam int EPOCH_WIDTH    = 8;

   typedef struct packed {
      logic signed [SAMPLE_WIDTH-1:0] i;
      logic signed [SAMPLE_WIDTH-1:0] q;
   } sample_t;

   typedef struct packed {
      logic [PRN_WIDTH-1:0]      prn;        // PRN minus one
      logic [CHIP_IDX_WIDTH-1:0] code_shift; // Chip index that restarts the code
   } chan_cfg_t;

   typedef struct packed {
      logic                      valid;
      sample_t                   sample;
      logic [CHIP_IDX_WIDTH-1:0] chip_index;
      logic [EPOCH_WIDTH-1:0]    epoch;
   } chip_tick_t;

   typedef struct packed {
      logic [CHAN_ID_WIDTH-1:0]   chan_id;
      logic [EPOCH_WIDTH-1:0]     epoch;
      logic signed [ACC_WIDTH-1:0] acc_i;
      logic signed [ACC_WIDTH-1:0] acc_q;
      logic [I2Q2_WIDTH-1:0]      i2q2;
      logic                       overrun; // Older result was lost
   } corr_result_t;

   // Four-phase handshake states, shared by input and output side
   typedef enum logic [1:0] {
      hs_idle,
      hs_wait_ack,
      hs_wait_release,
      hs_done
   } hs_state_e;

endpackage

`default_nettype wire

//--- logic/ca_code_gen.sv
`timescale 1ns/100ps
`default_nettype none

module ca_code_gen (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          load,
   input  logic                          step,
   input  logic [gps_pkg::PRN_WIDTH-1:0] prn,
   output logic                          chip
);

   logic [10:1] g1;     // Stage numbering as in the ICD
   logic [10:1] g2;
   logic [3:0]  tap_a;
   logic [3:0]  tap_b;

   // G2 phase selector taps, prn holds PRN minus one
   always_comb begin
      case (prn)
         5'd0:    {tap_a, tap_b} = {4'd2, 4'd6};
         5'd1:    {tap_a, tap_b} = {4'd3, 4'd7};
         5'd2:    {tap_a, tap_b} = {4'd4, 4'd8};
         5'd3:    {tap_a, tap_b} = {4'd5, 4'd9};
         5'd4:    {tap_a, tap_b} = {4'd1, 4'd9};
         5'd5:    {tap_a, tap_b} = {4'd2, 4'd10};
         5'd6:    {tap_a, tap_b} = {4'd1, 4'd8};
         5'd7:    {tap_a, tap_b} = {4'd2, 4'd9};
         5'd8:    {tap_a, tap_b} = {4'd3, 4'd10};
         5'd9:    {tap_a, tap_b} = {4'd2, 4'd3};
         5'd10:   {tap_a, tap_b} = {4'd3, 4'd4};
         5'd11:   {tap_a, tap_b} = {4'd5, 4'd6};
         5'd12:   {tap_a, tap_b} = {4'd6, 4'd7};
         5'd13:   {tap_a, tap_b} = {4'd7, 4'd8};
         5'd14:   {tap_a, tap_b} = {4'd8, 4'd9};
         5'd15:   {tap_a, tap_b} = {4'd9, 4'd10};
         5'd16:   {tap_a, tap_b} = {4'd1, 4'd4};
         5'd17:   {tap_a, tap_b} = {4'd2, 4'd5};
         5'd18:   {tap_a, tap_b} = {4'd3, 4'd6};
         5'd19:   {tap_a, tap_b} = {4'd4, 4'd7};
         5'd20:   {tap_a, tap_b} = {4'd5, 4'd8};
         5'd21:   {tap_a, tap_b} = {4'd6, 4'd9};
         5'd22:   {tap_a, tap_b} = {4'd1, 4'd3};
         5'd23:   {tap_a, tap_b} = {4'd4, 4'd6};
         5'd24:   {tap_a, tap_b} = {4'd5, 4'd7};
         5'd25:   {tap_a, tap_b} = {4'd6, 4'd8};
         5'd26:   {tap_a, tap_b} = {4'd7, 4'd9};
         5'd27:   {tap_a, tap_b} = {4'd8, 4'd10};
         5'd28:   {tap_a, tap_b} = {4'd1, 4'd6};
         5'd29:   {tap_a, tap_b} = {4'd2, 4'd7};
         5'd30:   {tap_a, tap_b} = {4'd3, 4'd8};
         default: {tap_a, tap_b} = {4'd4, 4'd9}; // PRN 32
      endcase
   end

   assign chip = g1[10] ^ g2[tap_a] ^ g2[tap_b];

   always_ff @(posedge clk) begin
      if (reset || load) begin
         g1 <= '1;                                              // Epoch start state
         g2 <= '1;
      end else if (step) begin
         g1 <= {g1[9:1], g1[3] ^ g1[10]};                       // 1 + x^3 + x^10
         g2 <= {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
      end
   end

endmodule

`default_nettype wire

//--- logic/sample_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module sample_dispatch (
   input  logic                clk,
   input  logic                reset,
   input  logic                sample_req,
   input  gps_pkg::sample_t    sample,
   output logic                sample_ack,
   output gps_pkg::chip_tick_t tick
);

   import gps_pkg::*;

   hs_state_e                 state;
   logic [CHIP_IDX_WIDTH-1:0] chip_cnt;
   logic [EPOCH_WIDTH-1:0]    epoch_cnt;
   logic                      accept;

   assign accept     = (state == hs_idle) && sample_req; // ack is low in idle
   assign sample_ack = (state == hs_wait_release);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= hs_idle;
      end else begin
         case (state)
            hs_idle:         if (accept) state <= hs_wait_release;
            hs_wait_release: if (!sample_req) state <= hs_idle; // ack drops next cycle
            default:         state <= hs_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         chip_cnt  <= '0;
         epoch_cnt <= '0;
      end else if (accept) begin
         if (chip_cnt == CHIP_IDX_WIDTH'(CODE_LEN - 1)) begin
            chip_cnt  <= '0;
            epoch_cnt <= epoch_cnt + 1'b1;                     // Epoch counts on wrap
         end else begin
            chip_cnt <= chip_cnt + 1'b1;
         end
      end
   end

   // Broadcast tick lines up with the rise of sample_ack
   always_ff @(posedge clk) begin
      if (reset) begin
         tick.valid <= 1'b0;
      end else begin
         tick.valid <= accept;
         if (accept) begin
            tick.sample     <= sample;
            tick.chip_index <= chip_cnt;
            tick.epoch      <= epoch_cnt;
         end
      end
   end

   a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
      $rose(sample_ack) |-> $past(sample_req))
      else $error("sample_ack rose without sample_req high");

endmodule

`default_nettype wire

//--- logic/correlator_channel.sv
`timescale 1ns/100ps
`default_nettype none

module correlator_channel (
   input  logic [gps_pkg::CHAN_ID_WIDTH-1:0] chan_id,
   input  logic                              clk,
   input  logic                              reset,
   input  gps_pkg::chan_cfg_t                cfg,
   input  gps_pkg::chip_tick_t               tick,
   input  logic                              take,
   output logic                              pending,
   output gps_pkg::corr_result_t             result
);

   import gps_pkg::*;

   logic                         chip;
   logic                         code_load;
   logic                         code_step;
   logic signed [ACC_WIDTH-1:0]  samp_i;
   logic signed [ACC_WIDTH-1:0]  samp_q;
   logic signed [ACC_WIDTH-1:0]  add_i;
   logic signed [ACC_WIDTH-1:0]  add_q;
   logic signed [ACC_WIDTH-1:0]  acc_i;
   logic signed [ACC_WIDTH-1:0]  acc_q;
   logic signed [I2Q2_WIDTH-1:0] sq_i;
   logic signed [I2Q2_WIDTH-1:0] sq_q;
   logic                         dump_q;
   logic [EPOCH_WIDTH-1:0]       dump_epoch;

   // Code phase restarts at the configured chip index
   assign code_load = tick.valid && (tick.chip_index == cfg.code_shift);
   assign code_step = tick.valid && !code_load;

   ca_code_gen u_code (
      .clk   (clk),
      .reset (reset),
      .load  (code_load),
      .step  (code_step),
      .prn   (cfg.prn),
      .chip  (chip)
   );

   assign samp_i = ACC_WIDTH'(tick.sample.i);                   // Sign extend
   assign samp_q = ACC_WIDTH'(tick.sample.q);
   assign add_i  = chip ? -samp_i : samp_i;                     // Chip 1 counts as -1
   assign add_q  = chip ? -samp_q : samp_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         acc_i <= '0;
         acc_q <= '0;
      end else if (dump_q) begin
         acc_i <= tick.valid ? add_i : '0;                      // Restart after dump
         acc_q <= tick.valid ? add_q : '0;
      end else if (tick.valid) begin
         acc_i <= acc_i + add_i;
         acc_q <= acc_q + add_q;
      end
   end

   // Last chip of the epoch, dump follows one cycle later
   always_ff @(posedge clk) begin
      if (reset) begin
         dump_q <= 1'b0;
      end else begin
         dump_q <= tick.valid && (tick.chip_index == CHIP_IDX_WIDTH'(CODE_LEN - 1));
      end
   end

   always_ff @(posedge clk) begin
      if (tick.valid) begin
         dump_epoch <= tick.epoch;
      end
   end

   assign sq_i = I2Q2_WIDTH'(acc_i) * I2Q2_WIDTH'(acc_i);
   assign sq_q = I2Q2_WIDTH'(acc_q) * I2Q2_WIDTH'(acc_q);

   always_ff @(posedge clk) begin
      if (dump_q) begin
         result.chan_id <= chan_id;
         result.epoch   <= dump_epoch;
         result.acc_i   <= acc_i;
         result.acc_q   <= acc_q;
         result.i2q2    <= sq_i + sq_q;
         result.overrun <= pending && !take;                    // Old result never taken
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pending <= 1'b0;
      end else if (dump_q) begin
         pending <= 1'b1;
      end else if (take) begin
         pending <= 1'b0;
      end
   end

   a_take_when_pending: assert property (@(posedge clk) disable iff (reset)
      take |-> pending)
      else $error("Channel %0d taken with no pending result", chan_id);

endmodule

`default_nettype wire

//--- logic/result_collector.sv
`timescale 1ns/100ps
`default_nettype none

module result_collector (
   input  logic                              clk,
   input  logic                              reset,
   input  logic [gps_pkg::N_CHANNELS-1:0]    pending,
   input  gps_pkg::corr_result_t             chan_results [gps_pkg::N_CHANNELS],
   output logic [gps_pkg::N_CHANNELS-1:0]    take,
   output logic                              res_req,
   output gps_pkg::corr_result_t             result,
   input  logic                              res_ack,
   output logic [gps_pkg::I2Q2_WIDTH-1:0]    peak_i2q2,
   output logic [gps_pkg::CHAN_ID_WIDTH-1:0] peak_chan
);

   import gps_pkg::*;

   hs_state_e                state;
   logic [CHAN_ID_WIDTH-1:0] ptr;         // Round-robin start point
   logic [CHAN_ID_WIDTH-1:0] sel;
   logic [CHAN_ID_WIDTH-1:0] cand;
   logic                     any_pending;
   logic                     grant;

   // Lowest pending index at or after ptr, searched backwards so the nearest wins
   always_comb begin
      any_pending = 1'b0;
      sel         = ptr;
      cand        = ptr;
      for (int k = N_CHANNELS - 1; k >= 0; k--) begin
         cand = CHAN_ID_WIDTH'((int'(ptr) + k) % N_CHANNELS);
         if (pending[cand]) begin
            sel         = cand;
            any_pending = 1'b1;
         end
      end
   end

   assign grant   = (state == hs_idle) && any_pending;         // Scan only when idle
   assign take    = grant ? (N_CHANNELS'(1) << sel) : '0;
   assign res_req = (state == hs_wait_ack);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= hs_idle;
         ptr   <= '0;
      end else begin
         case (state)
            hs_idle: begin
               if (grant) begin
                  state <= hs_wait_ack;
                  ptr   <= (sel == CHAN_ID_WIDTH'(N_CHANNELS - 1)) ? '0 : sel + 1'b1;
               end
            end
            hs_wait_ack:     if (res_ack) state <= hs_wait_release;
            hs_wait_release: if (!res_ack) state <= hs_done;
            hs_done:         state <= hs_idle;                  // Spare cycle before rescan
            default:         state <= hs_idle;
         endcase
      end
   end

   // Copy held from take until res_ack has fallen
   always_ff @(posedge clk) begin
      if (grant) begin
         result <= chan_results[sel];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         peak_i2q2 <= '0;
         peak_chan <= '0;
      end else if (grant && (chan_results[sel].i2q2 > peak_i2q2)) begin
         peak_i2q2 <= chan_results[sel].i2q2;                  // Visible as res_req rises
         peak_chan <= chan_results[sel].chan_id;
      end
   end

   a_result_stable: assert property (@(posedge clk) disable iff (reset)
      res_req && $past(res_req) |-> $stable(result))
      else $error("result changed while res_req was high");

   a_one_take: assert property (@(posedge clk) disable iff (reset)
      $onehot0(take))
      else $error("More than one channel taken in a cycle");

endmodule

`default_nettype wire

//--- logic/gps_correlator_top.sv
`timescale 1ns/100ps
`default_nettype none

module gps_correlator_top (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              sample_req,
   input  gps_pkg::sample_t                  sample,
   output logic                              sample_ack,
   input  gps_pkg::chan_cfg_t                chan_cfg [gps_pkg::N_CHANNELS],
   output logic                              res_req,
   output gps_pkg::corr_result_t             result,
   input  logic                              res_ack,
   output logic [gps_pkg::I2Q2_WIDTH-1:0]    peak_i2q2,
   output logic [gps_pkg::CHAN_ID_WIDTH-1:0] peak_chan
);

   import gps_pkg::*;

   chip_tick_t             tick;                                // Shared by all channels
   corr_result_t           chan_results [N_CHANNELS];
   logic [N_CHANNELS-1:0]  pending;
   logic [N_CHANNELS-1:0]  take;

   sample_dispatch u_dispatch (
      .clk        (clk),
      .reset      (reset),
      .sample_req (sample_req),
      .sample     (sample),
      .sample_ack (sample_ack),
      .tick       (tick)
   );

   for (genvar g = 0; g < N_CHANNELS; g++) begin : g_chan
      correlator_channel u_chan (
         .chan_id (CHAN_ID_WIDTH'(g)),
         .clk     (clk),
         .reset   (reset),
         .cfg     (chan_cfg[g]),
         .tick    (tick),
         .take    (take[g]),
         .pending (pending[g]),
         .result  (chan_results[g])
      );
   end

   result_collector u_collect (
      .clk          (clk),
      .reset        (reset),
      .pending      (pending),
      .chan_results (chan_results),
      .take         (take),
      .res_req      (res_req),
      .result       (result),
      .res_ack      (res_ack),
      .peak_i2q2    (peak_i2q2),
      .peak_chan    (peak_chan)
   );

endmodule

`default_nettype wire

//--- tests/tb_ca_model.svh
`ifndef TB_CA_MODEL_SVH
`define TB_CA_MODEL_SVH

// G2 delay in chips for PRN 1 to 32
localparam int G2_DELAY [32] = '{
   5, 6, 7, 8, 17, 18, 139, 140, 141, 251, 252, 254, 255, 256, 257, 258,
   469, 470, 471, 472, 473, 474, 509, 512, 513, 514, 515, 516, 859, 860, 861, 862};

bit ca_table [32][CODE_LEN];                  // Chip per PRN minus one and code phase
int drv_i    [2*CODE_LEN];                    // Samples as driven
int drv_q    [2*CODE_LEN];
int model_i  [N_CHANNELS][2];                 // Expected sums per epoch
int model_q  [N_CHANNELS][2];

function automatic void build_ca_tables();
   bit [9:0] g1;
   bit [9:0] g2;
   bit       g1_out [CODE_LEN];
   bit       g2_out [CODE_LEN];
   g1 = '1;
   g2 = '1;
   for (int k = 0; k < CODE_LEN; k++) begin
      g1_out[k] = g1[9];
      g2_out[k] = g2[9];
      g1 = {g1[8:0], g1[2] ^ g1[9]};
      g2 = {g2[8:0], g2[1] ^ g2[2] ^ g2[5] ^ g2[7] ^ g2[8] ^ g2[9]};
   end
   // Gold code as G1 xor the delayed G2 sequence
   for (int p = 0; p < 32; p++) begin
      for (int k = 0; k < CODE_LEN; k++) begin
         ca_table[p][k] = g1_out[k] ^ g2_out[(k + CODE_LEN - G2_DELAY[p]) % CODE_LEN];
      end
   end
endfunction

// Phase used on the next tick, restart after the shift chip
function automatic int next_phase(int phase, int chip_index, int shift);
   return (chip_index == shift) ? 0 : (phase + 1) % CODE_LEN;
endfunction

function automatic void correlate(int prn [N_CHANNELS], int shift [N_CHANNELS]);
   int phase;
   int sgn;
   for (int c = 0; c < N_CHANNELS; c++) begin
      phase = 0;                              // Generator starts in its initial state
      model_i[c] = '{0, 0};
      model_q[c] = '{0, 0};
      for (int k = 0; k < 2 * CODE_LEN; k++) begin
         sgn = ca_table[prn[c] - 1][phase] ? -1 : 1;
         model_i[c][k / CODE_LEN] += sgn * drv_i[k];
         model_q[c][k / CODE_LEN] += sgn * drv_q[k];
         phase = next_phase(phase, k % CODE_LEN, shift[c]);
      end
   end
endfunction

`endif

//--- tests/tb_gps_correlator.sv
`timescale 1ns/100ps
`default_nettype none

module tb_gps_correlator;

   import gps_pkg::*;

   localparam int MAX_TESTS  = 16;
   localparam int SAMPLE_MAX = 3;
   localparam int SAMPLE_MIN = -4;

   logic                     clk;
   logic                     reset;
   logic                     sample_req;
   sample_t                  sample;
   logic                     sample_ack;
   chan_cfg_t                chan_cfg [N_CHANNELS];
   logic                     res_req;
   corr_result_t             result;
   logic                     res_ack;
   logic [I2Q2_WIDTH-1:0]    peak_i2q2;
   logic [CHAN_ID_WIDTH-1:0] peak_chan;

   string test_name  [MAX_TESTS];
   int    cfg_prn    [MAX_TESTS][N_CHANNELS];
   int    cfg_shift  [MAX_TESTS][N_CHANNELS];
   int    sig_prn    [MAX_TESTS];
   int    sig_shift  [MAX_TESTS];
   int    amp_i      [MAX_TESTS];
   int    amp_q      [MAX_TESTS];
   int    noise_flag [MAX_TESTS];
   int    stall_flag [MAX_TESTS];
   int    peak_ref   [MAX_TESTS];
   int    n_tests;
   int    seed = 32'h7568;
   int    watchdog_cycles = 0;
   int    exp_peak;

   `include "tb_ca_model.svh"

   gps_correlator_top u_dut (
      .clk        (clk),
      .reset      (reset),
      .sample_req (sample_req),
      .sample     (sample),
      .sample_ack (sample_ack),
      .chan_cfg   (chan_cfg),
      .res_req    (res_req),
      .result     (result),
      .res_ack    (res_ack),
      .peak_i2q2  (peak_i2q2),
      .peak_chan  (peak_chan)
   );

   always #5 clk = ~clk;

   task automatic abort_run(string msg);
      $display("%0s", msg);
      $display("Test failed");
      $fatal(1, "Simulation stopped on error");
   endtask

   function automatic string show_result(corr_result_t r);
      return $sformatf("chan %0d epoch %0d i %0d q %0d i2q2 %0d overrun %0b",
                       r.chan_id, r.epoch, r.acc_i, r.acc_q, r.i2q2, r.overrun);
   endfunction

   task automatic check_result(string name, corr_result_t expected, corr_result_t actual);
      if (actual !== expected) begin
         abort_run($sformatf("Fail %0s: expected %0s, actual %0s", name,
                             show_result(expected), show_result(actual)));
      end
   endtask

   task automatic check_peak(string name, logic [I2Q2_WIDTH-1:0] exp_i2q2,
                             logic [CHAN_ID_WIDTH-1:0] exp_chan);
      if (peak_i2q2 !== exp_i2q2 || peak_chan !== exp_chan) begin
         abort_run($sformatf("Fail %0s: expected peak %0d on chan %0d, actual %0d on chan %0d",
                             name, exp_i2q2, exp_chan, peak_i2q2, peak_chan));
      end
   endtask

   task automatic read_stimulus();
      int              fd;
      int              cnt;
      string           line;
      logic [8*32-1:0] name_bits;
      fd = $fopen("tests/correlator_stimulus.txt", "r");
      if (fd == 0) abort_run("Could not open tests/correlator_stimulus.txt");
      n_tests = 0;
      while (!$feof(fd) && n_tests < MAX_TESTS) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line.substr(0, 0) == "#") continue;
         cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d", name_bits,
                       cfg_prn[n_tests][0], cfg_shift[n_tests][0], cfg_prn[n_tests][1],
                       cfg_shift[n_tests][1], cfg_prn[n_tests][2], cfg_shift[n_tests][2],
                       cfg_prn[n_tests][3], cfg_shift[n_tests][3], sig_prn[n_tests],
                       sig_shift[n_tests], amp_i[n_tests], amp_q[n_tests],
                       noise_flag[n_tests], stall_flag[n_tests], peak_ref[n_tests]);
         if (cnt != 16) abort_run($sformatf("Stimulus line could not be parsed: %0s", line));
         test_name[n_tests] = $sformatf("%0s", name_bits);
         n_tests++;
      end
      $fclose(fd);
   endtask

   // Random step of one folded back into the 3-bit range
   function automatic int add_noise(int value, int enable);
      int step;
      if (enable == 0) return value;
      step = ($random(seed) & 1) ? 1 : -1;
      if (value + step > SAMPLE_MAX || value + step < SAMPLE_MIN) step = -step;
      return value + step;
   endfunction

   task automatic build_samples(int t);
      int phase;
      int sgn;
      phase = 0;
      for (int k = 0; k < 2 * CODE_LEN; k++) begin
         sgn = ca_table[sig_prn[t] - 1][phase] ? -1 : 1;
         drv_i[k] = add_noise(sgn * amp_i[t], noise_flag[t]);
         drv_q[k] = add_noise(sgn * amp_q[t], noise_flag[t]);
         phase = next_phase(phase, k % CODE_LEN, sig_shift[t]);
      end
   endtask

   task automatic send_samples();
      for (int k = 0; k < 2 * CODE_LEN; k++) begin
         if (sample_ack !== 1'b0) abort_run("sample_ack was high before sample_req rose");
         sample_req = 1'b1;
         sample.i   = SAMPLE_WIDTH'(drv_i[k]);
         sample.q   = SAMPLE_WIDTH'(drv_q[k]);
         @(negedge clk);
         if (sample_ack !== 1'b1) abort_run("sample_ack did not rise one cycle after sample_req");
         sample_req = 1'b0;
         @(negedge clk);
         if (sample_ack !== 1'b0) abort_run("sample_ack stayed high after sample_req fell");
      end
   endtask

   task automatic collect_results(int t);
      corr_result_t expected;
      int           n_exp;
      int           c;
      int           e;
      int           energy;
      int           delay;
      n_exp = stall_flag[t] ? N_CHANNELS + 1 : 2 * N_CHANNELS;
      for (int n = 0; n < n_exp; n++) begin
         while (res_req !== 1'b1) @(negedge clk);
         c = n % N_CHANNELS;                  // Pointer starts at channel 0 after reset
         e = stall_flag[t] ? (n == 0 ? 0 : 1) : n / N_CHANNELS;
         energy = model_i[c][e] * model_i[c][e] + model_q[c][e] * model_q[c][e];
         expected.chan_id = CHAN_ID_WIDTH'(c);
         expected.epoch   = EPOCH_WIDTH'(e);
         expected.acc_i   = ACC_WIDTH'(model_i[c][e]);
         expected.acc_q   = ACC_WIDTH'(model_q[c][e]);
         expected.i2q2    = I2Q2_WIDTH'(energy);
         expected.overrun = stall_flag[t] && c != 0; // Epoch 0 lost while the first ack waits
         check_result(test_name[t], expected, result);
         if (energy > exp_peak) exp_peak = energy;
         delay = $unsigned($random(seed)) % 4;
         if (stall_flag[t] && n == 0) delay = 4 * CODE_LEN; // Past the end of both epochs
         for (int d = 0; d < delay; d++) begin
            @(negedge clk);
            if (res_req !== 1'b1) abort_run("res_req fell before res_ack rose");
         end
         res_ack = 1'b1;
         @(negedge clk);
         while (res_req !== 1'b0) @(negedge clk);
         res_ack = 1'b0;
      end
   endtask

   task automatic run_test(int t);
      int prn   [N_CHANNELS];
      int shift [N_CHANNELS];
      @(negedge clk);
      reset = 1'b1;
      for (int c = 0; c < N_CHANNELS; c++) begin
         prn[c]   = cfg_prn[t][c];
         shift[c] = cfg_shift[t][c];
         chan_cfg[c].prn        = PRN_WIDTH'(prn[c] - 1);
         chan_cfg[c].code_shift = CHIP_IDX_WIDTH'(shift[c]);
      end
      repeat (10) @(negedge clk);
      reset    = 1'b0;
      exp_peak = 0;
      build_samples(t);
      correlate(prn, shift);
      fork
         send_samples();
         collect_results(t);
      join
      repeat (40) @(negedge clk);
      if (res_req !== 1'b0) abort_run($sformatf("%0s: extra result offered", test_name[t]));
      check_peak(test_name[t], I2Q2_WIDTH'(exp_peak), CHAN_ID_WIDTH'(peak_ref[t]));
   endtask

   initial begin
      clk        = 1'b0;
      reset      = 1'b1;
      sample_req = 1'b0;
      sample     = '0;
      res_ack    = 1'b0;
      for (int c = 0; c < N_CHANNELS; c++) begin
         chan_cfg[c] = '0;
      end
      build_ca_tables();
      read_stimulus();
      watchdog_cycles = n_tests * 2 * CODE_LEN * 8 + 2000;
      for (int t = 0; t < n_tests; t++) begin
         run_test(t);
      end
      if (n_tests == 0) begin
         abort_run("No tests were read from the stimulus file");
      end else begin
         $display("Test passed");
         $finish;
      end
   end

   initial begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      abort_run($sformatf("Run timed out after %0d cycles", watchdog_cycles));
   end

endmodule

`default_nettype wire

//--- tests/correlator_stimulus.txt
# name prn0 shift0 prn1 shift1 prn2 shift2 prn3 shift3 sig_prn sig_shift amp_i amp_q
# noise stall peak_chan (PRN 1 to 32, shift is the chip index that restarts the code)
match_ch0_clean       1    0  5  100 12 500 20 1022   1    0  3 -2  0 0 0
match_ch2_shifted     3   17  3  400  7 200 31  900   7  200 -3  3  0 0 2
noisy_ch1             2    0  9  333 24 700 32   12   9  333  2  2  1 0 1
same_prn_other_shift 14   10 14   11 14 600 19   50  14  600  1 -3  1 0 2
stall_ch3_clean       4    5 10  250 13 777 28 1000  28 1000  3  3  0 1 3
stall_ch1_noisy       6   64 17  128 22 256 30  512  17  128 -2  1  1 1 1

//--- filelist.f
+incdir+tests
logic/gps_pkg.sv
logic/ca_code_gen.sv
logic/sample_dispatch.sv
logic/correlator_channel.sv
logic/result_collector.sv
logic/gps_correlator_top.sv
tests/tb_gps_correlator.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the correlator testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_gps_correlator \
   -f filelist.f -o sim_tb
sim_out=$(./obj_dir/sim_tb 2>&1 || true)
echo "$sim_out"
if grep -qx "Test passed" <<< "$sim_out"; then
   exit 0
else
   exit 1
fi
